//--- Makefile
LOG := sim.log

.PHONY: sim clean

# build, run, then fail on the fail message in the log
sim:
	verilator --binary --timing --top-module tbMipsCore -f mipsCore.f -Mdir obj_dir
	./obj_dir/VtbMipsCore > $(LOG)
	cat $(LOG)
	! grep -q "TEST FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- mipsCore.f
src/mipsPkg.sv
src/pcUnit.sv
src/ctrlDecode.sv
src/regFile.sv
src/aluUnit.sv
src/mipsCore.sv
verif/clkGen.sv
verif/tbMipsCore.sv

//--- src/aluUnit.sv
`default_nettype none

module aluUnit (
  input  logic [mipsPkg::dataWidth-1:0] operandA,
  input  logic [mipsPkg::dataWidth-1:0] operandB,
  input  mipsPkg::aluOpT                aluOp,
  output logic [mipsPkg::dataWidth-1:0] result,
  output logic                          zero
);

  import mipsPkg::*;

  // ==========================================================================
  // datapath results
  // ==========================================================================

  // sum for add, lw, sw
  logic [dataWidth-1:0] sumVal;
  // difference for sub and beq
  logic [dataWidth-1:0] diffVal;
  // slt flag, unsigned compare
  logic                 lessThan;

  assign sumVal   = operandA + operandB;
  assign diffVal  = operandA - operandB;
  assign lessThan = (operandA < operandB);

  // ==========================================================================
  // result select
  // ==========================================================================

  always_comb begin
    case (aluOp)
      aluAdd: begin
        result = sumVal;
      end
      aluSub: begin
        result = diffVal;
      end
      aluAnd: begin
        result = operandA & operandB;
      end
      aluOr: begin
        result = operandA | operandB;
      end
      aluSlt: begin
        // 1 or 0 in the low bit
        result = {{(dataWidth-1){1'b0}}, lessThan};
      end
      default: begin
        // aluNone
        result = '0;
      end
    endcase
  end

  // flag for every op, decoder decides if it matters
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- src/ctrlDecode.sv
`default_nettype none

module ctrlDecode (
  input  mipsPkg::opcodeT opcode,
  input  logic [5:0]      funct,
  output logic            regDst,
  output logic            aluSrc,
  output logic            memToReg,
  output logic            regWrite,
  output logic            memRead,
  output logic            memWrite,
  output logic            branch,
  output logic            jump,
  output logic            link,
  output mipsPkg::aluOpT  aluOp
);

  import mipsPkg::*;

  // ==========================================================================
  // main control plus alu control in one table
  // ==========================================================================

  always_comb begin
    // idle defaults, unknown opcode ends up here
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    aluOp    = aluNone;
    case (opcode)
      opR: begin
        // rd destination, op from funct
        regDst   = 1'b1;
        regWrite = 1'b1;
        case (funct)
          fnAdd:   aluOp = aluAdd;
          fnSub:   aluOp = aluSub;
          fnAnd:   aluOp = aluAnd;
          fnOr:    aluOp = aluOr;
          fnSlt:   aluOp = aluSlt;
          // all-zero word lands here and writes zero to r0
          default: aluOp = aluNone;
        endcase
      end
      opLw: begin
        // base plus offset, load into rt
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
        aluOp    = aluAdd;
      end
      opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
        aluOp    = aluAdd;
      end
      opBeq: begin
        // equality through a zero difference
        branch = 1'b1;
        aluOp  = aluSub;
      end
      opJ: begin
        jump = 1'b1;
      end
      opJal: begin
        // return address into r31
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/mipsCore.sv
`default_nettype none

module mipsCore #(
  parameter int memAddrWidth = 7
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [mipsPkg::dataWidth-1:0] ir,
  input  logic [mipsPkg::dataWidth-1:0] memReadData,
  output logic [mipsPkg::dataWidth-1:0] irAddr,
  output logic [mipsPkg::dataWidth-1:0] rfWriteData,
  output logic                          cen,
  output logic                          wen,
  output logic [memAddrWidth-1:0]       memAddr,
  output logic [mipsPkg::dataWidth-1:0] memWriteData
);

  import mipsPkg::*;

  // ==========================================================================
  // instruction fields
  // ==========================================================================

  opcodeT                  opcode;
  logic [5:0]              funct;
  logic [regAddrWidth-1:0] rs;
  logic [regAddrWidth-1:0] rt;
  logic [regAddrWidth-1:0] rd;
  logic [15:0]             imm;
  logic [25:0]             target;
  // sign-extended immediate
  logic [dataWidth-1:0]    immExt;

  assign opcode = opcodeT'(ir[31:26]);
  assign rs     = ir[25:21];
  assign rt     = ir[20:16];
  assign rd     = ir[15:11];
  assign imm    = ir[15:0];
  assign funct  = ir[5:0];
  assign target = ir[25:0];
  assign immExt = {{16{imm[15]}}, imm};

  // decoder outputs
  logic   regDst, aluSrc, memToReg, regWrite;
  logic   memRead, memWrite, branch, jump, link;
  aluOpT  aluOp;

  // datapath nets
  logic [regAddrWidth-1:0] writeAddr;
  logic [dataWidth-1:0]    readData1, readData2;
  logic [dataWidth-1:0]    operandB, aluResult, wbData, pcPlus8;
  logic                    zero;

  // ==========================================================================
  // blocks
  // ==========================================================================

  pcUnit uPc (
    .clk(clk), .rst(rst), .branch(branch), .jump(jump), .zero(zero),
    .immExt(immExt), .jumpTarget(target), .pc(irAddr), .pcPlus8(pcPlus8)
  );

  ctrlDecode uDec (
    .opcode(opcode), .funct(funct), .regDst(regDst), .aluSrc(aluSrc),
    .memToReg(memToReg), .regWrite(regWrite), .memRead(memRead),
    .memWrite(memWrite), .branch(branch), .jump(jump), .link(link),
    .aluOp(aluOp)
  );

  regFile uRf (
    .clk(clk), .rst(rst), .writeEn(regWrite), .readAddr1(rs), .readAddr2(rt),
    .writeAddr(writeAddr), .writeData(wbData),
    .readData1(readData1), .readData2(readData2)
  );

  aluUnit uAlu (
    .operandA(readData1), .operandB(operandB), .aluOp(aluOp),
    .result(aluResult), .zero(zero)
  );

  // destination register, r31 for jal
  assign writeAddr = link ? regAddrWidth'(linkReg) : (regDst ? rd : rt);
  // immediate for lw / sw
  assign operandB  = aluSrc ? immExt : readData2;
  // writeback source
  assign wbData    = link ? pcPlus8 : (memToReg ? memReadData : aluResult);

  // observed writeback, zero when nothing is written
  assign rfWriteData = regWrite ? wbData : '0;

  // sram pins, strobes active low
  assign cen          = ~(memRead | memWrite);
  assign wen          = ~memWrite;
  // word address from the byte address
  assign memAddr      = aluResult[memAddrWidth+1:2];
  assign memWriteData = readData2;

endmodule

`default_nettype wire

//--- src/mipsPkg.sv
`default_nettype none

package mipsPkg;

  // ==========================================================================
  // shared widths
  // ==========================================================================

  // machine word
  localparam int dataWidth = 32;
  // register index
  localparam int regAddrWidth = 5;
  // return address register for jal
  localparam int linkReg = 31;

  // ==========================================================================
  // instruction encodings
  // ==========================================================================

  // primary opcode in ir[31:26]
  typedef enum logic [5:0] {
    opR   = 6'd0,
    opJ   = 6'd2,
    opJal = 6'd3,
    opBeq = 6'd4,
    opLw  = 6'd35,
    opSw  = 6'd43
  } opcodeT;

  // funct field of r-type, ir[5:0]
  typedef enum logic [5:0] {
    fnAdd = 6'd32,
    fnSub = 6'd34,
    fnAnd = 6'd36,
    fnOr  = 6'd37,
    fnSlt = 6'd42
  } functT;

  // alu operation select
  // aluNone drives a zero result
  typedef enum logic [2:0] {
    aluAdd  = 3'd0,
    aluSub  = 3'd1,
    aluAnd  = 3'd2,
    aluOr   = 3'd3,
    aluSlt  = 3'd4,
    aluNone = 3'd5
  } aluOpT;

endpackage

`default_nettype wire

//--- src/pcUnit.sv
`default_nettype none

module pcUnit (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         branch,
  input  logic                         jump,
  input  logic                         zero,
  input  logic [mipsPkg::dataWidth-1:0] immExt,
  input  logic [25:0]                  jumpTarget,
  output logic [mipsPkg::dataWidth-1:0] pc,
  output logic [mipsPkg::dataWidth-1:0] pcPlus8
);

  import mipsPkg::*;

  // current instruction address
  logic [dataWidth-1:0] pcReg;
  // sequential successor
  logic [dataWidth-1:0] pcPlus4;
  // beq destination
  logic [dataWidth-1:0] branchAddr;
  // j / jal destination
  logic [dataWidth-1:0] jumpAddr;

  assign pcPlus4 = pcReg + 32'd4;
  // link value for jal
  assign pcPlus8 = pcReg + 32'd8;
  // word offset turned into a byte offset
  assign branchAddr = pcPlus4 + (immExt << 2);
  // region bits stay from pc+4
  assign jumpAddr = {pcPlus4[31:28], jumpTarget, 2'b00};

  // jump wins over branch, no delay slot
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else if (jump) begin
      pcReg <= jumpAddr;
    end else if (branch && zero) begin
      pcReg <= branchAddr;
    end else begin
      pcReg <= pcPlus4;
    end
  end

  assign pc = pcReg;

endmodule

`default_nettype wire

//--- src/regFile.sv
`default_nettype none

module regFile (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            writeEn,
  input  logic [mipsPkg::regAddrWidth-1:0] readAddr1,
  input  logic [mipsPkg::regAddrWidth-1:0] readAddr2,
  input  logic [mipsPkg::regAddrWidth-1:0] writeAddr,
  input  logic [mipsPkg::dataWidth-1:0]    writeData,
  output logic [mipsPkg::dataWidth-1:0]    readData1,
  output logic [mipsPkg::dataWidth-1:0]    readData2
);

  import mipsPkg::*;

  // general purpose registers
  logic [dataWidth-1:0] regs [0:(1 << regAddrWidth)-1];

  // whole file cleared on reset
  // r0 never written
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < (1 << regAddrWidth); i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  // combinational reads
  // r0 forced to zero
  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

//--- verif/clkGen.sv
`default_nettype none

module clkGen #(
  parameter int period = 40,
  parameter int resetCycles = 10
) (
  output logic clk,
  output logic rst
);

  // free-running clock, starts low
  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // reset held low, released on a falling edge
  initial begin
    rst = 1'b0;
    repeat (resetCycles) @(negedge clk);
    rst = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tbMipsCore.sv
`default_nettype none

module tbMipsCore;

  import mipsPkg::*;

  localparam int memAddrWidth = 7;
  localparam int memWords = 1 << memAddrWidth;
  localparam int randomSteps = 60;

  logic clk, rst, cen, wen;
  logic [31:0] ir, memReadData, irAddr, rfWriteData, memWriteData;
  logic [memAddrWidth-1:0] memAddr;

  // instruction and data memories seen by the dut
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:memWords-1];
  // reference model state
  logic [31:0] mDmem [0:memWords-1];
  logic [31:0] mRegs [0:31];
  logic [31:0] mPc;
  // byte address where each test's code ends
  logic [31:0] secEnd [0:5];
  string secName [0:5];
  functT fnList [0:4];
  int errors = 0, checks = 0, testFails = 0, progLen = 0, cycles = 0, cycleLimit = 1000;

  clkGen #(.period(40), .resetCycles(10)) uClk (.clk(clk), .rst(rst));

  mipsCore #(.memAddrWidth(memAddrWidth)) dut (
    .clk(clk), .rst(rst), .ir(ir), .memReadData(memReadData), .irAddr(irAddr),
    .rfWriteData(rfWriteData), .cen(cen), .wen(wen), .memAddr(memAddr),
    .memWriteData(memWriteData)
  );

  // fetch and sram read, both combinational
  assign ir = imem[irAddr[9:2]];
  assign memReadData = !cen ? dmem[memAddr] : 32'd0;

  // store lands at the rising edge
  always @(posedge clk) begin
    if (!cen && !wen) begin
      dmem[memAddr] <= memWriteData;
    end
  end

  // run limit from the program length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout: the program did not reach its end within %0d cycles", cycleLimit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic emit(input logic [31:0] word);
    imem[progLen] = word;
    progLen++;
  endtask

  // ==========================================================================
  // instruction encoders
  // ==========================================================================

  function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
      input logic [4:0] rd, input functT fn);
    return {opR, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encodeI(input opcodeT op, input logic [4:0] rs,
      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encodeJ(input opcodeT op, input logic [25:0] target);
    return {op, target};
  endfunction

  // ==========================================================================
  // reference model, one instruction against the model state
  // ==========================================================================

  function automatic void refStep(input logic [31:0] pc, input logic [31:0] instr,
      output logic [31:0] nextPc, output logic [4:0] wrAddr, output logic [31:0] wrVal,
      output logic wrEn, output logic isLoad, output logic isStore,
      output logic [31:0] effAddr);
    logic [31:0] a, b, immExt, pc4;
    a = mRegs[instr[25:21]];
    b = mRegs[instr[20:16]];
    immExt = {{16{instr[15]}}, instr[15:0]};
    effAddr = a + immExt;
    pc4 = pc + 32'd4;
    nextPc = pc4;
    wrAddr = instr[20:16];
    wrVal = 32'd0;
    wrEn = 1'b0;
    isLoad = 1'b0;
    isStore = 1'b0;
    case (instr[31:26])
      opR: begin
        wrEn = 1'b1;
        wrAddr = instr[15:11];
        case (instr[5:0])
          fnAdd: wrVal = a + b;
          fnSub: wrVal = a - b;
          fnAnd: wrVal = a & b;
          fnOr: wrVal = a | b;
          // unsigned compare
          fnSlt: wrVal = (a < b) ? 32'd1 : 32'd0;
          default: wrVal = 32'd0;
        endcase
      end
      opLw: begin
        wrEn = 1'b1;
        isLoad = 1'b1;
        wrVal = mDmem[effAddr[memAddrWidth+1:2]];
      end
      opSw: isStore = 1'b1;
      opBeq: nextPc = (a == b) ? pc4 + (immExt << 2) : pc4;
      opJ, opJal: begin
        nextPc = {pc4[31:28], instr[25:0], 2'b00};
        // link is own address plus 8
        wrEn = (instr[31:26] == opJal);
        wrAddr = 5'd31;
        wrVal = wrEn ? pc + 32'd8 : 32'd0;
      end
      default: begin
      end
    endcase
  endfunction

  initial begin
    logic [31:0] instr, nextPc, wrVal, effAddr, word;
    logic [15:0] offset;
    logic [4:0] wrAddr, rs, rt, rd;
    logic wrEn, isLoad, isStore;
    int cur, secStart, kind;
    secName = '{"reset", "r-type", "load/store", "branches", "jumps", "random"};
    fnList = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt};
    void'($urandom(32'hc049_5f1d));
    // unused slots trap in a jump to themselves
    for (int i = 0; i < 256; i++) begin
      imem[i] = encodeJ(opJ, 26'(i));
    end
    for (int i = 0; i < memWords; i++) begin
      word = $urandom;
      dmem[i] <= word;
      mDmem[i] = word;
    end
    for (int i = 0; i < 32; i++) begin
      mRegs[i] = 32'd0;
    end
    mPc = 32'd0;
    // reset, every register read back in pairs through an or into r0
    for (int i = 1; i < 32; i += 2) begin
      emit(encodeR(5'(i), 5'(i + 1), 5'd0, fnOr));
    end
    secEnd[0] = 32'(progLen * 4);
    // random operands, then each r-type op, r0 write ignored
    emit(encodeI(opLw, 5'd0, 5'd1, 16'h0000));
    emit(encodeI(opLw, 5'd0, 5'd2, 16'h0004));
    emit(encodeR(5'd1, 5'd2, 5'd4, fnAdd));
    emit(encodeR(5'd1, 5'd2, 5'd5, fnSub));
    emit(encodeR(5'd1, 5'd2, 5'd6, fnAnd));
    emit(encodeR(5'd1, 5'd2, 5'd7, fnOr));
    emit(encodeR(5'd1, 5'd2, 5'd8, fnSlt));
    emit(encodeR(5'd1, 5'd2, 5'd0, fnAdd));
    emit(encodeR(5'd0, 5'd1, 5'd9, fnOr));
    secEnd[1] = 32'(progLen * 4);
    // store then reload, fixed and register-based addresses
    emit(encodeI(opSw, 5'd0, 5'd4, 16'h0028));
    emit(encodeI(opLw, 5'd0, 5'd11, 16'h0028));
    emit(encodeI(opSw, 5'd1, 5'd5, 16'h0010));
    emit(encodeI(opLw, 5'd1, 5'd12, 16'h0010));
    secEnd[2] = 32'(progLen * 4);
    // forward taken, forward over, backward taken, not taken
    emit(encodeI(opBeq, 5'd1, 5'd1, 16'h0002));
    emit(encodeR(5'd1, 5'd1, 5'd20, fnAdd));
    emit(encodeI(opBeq, 5'd0, 5'd0, 16'h0002));
    emit(encodeI(opBeq, 5'd0, 5'd0, 16'hfffe));
    emit(encodeR(5'd1, 5'd1, 5'd21, fnAdd));
    emit(encodeI(opBeq, 5'd1, 5'd2, 16'h0005));
    secEnd[3] = 32'(progLen * 4);
    // j over one slot, jal over one slot, then read r31
    emit(encodeJ(opJ, 26'(progLen + 2)));
    emit(encodeR(5'd1, 5'd1, 5'd22, fnAdd));
    emit(encodeJ(opJal, 26'(progLen + 2)));
    emit(encodeR(5'd1, 5'd1, 5'd23, fnAdd));
    emit(encodeR(5'd31, 5'd0, 5'd15, fnOr));
    secEnd[4] = 32'(progLen * 4);
    for (int k = 0; k < randomSteps; k++) begin
      kind = $urandom % 3;
      rs = 5'($urandom);
      rt = 5'($urandom);
      rd = 5'($urandom);
      offset = {7'd0, 7'($urandom), 2'b00};
      case (kind)
        0: word = encodeI(opLw, rs, rt, offset);
        1: word = encodeI(opSw, rs, rt, offset);
        default: word = encodeR(rs, rt, rd, fnList[$urandom % 5]);
      endcase
      emit(word);
    end
    secEnd[5] = 32'(progLen * 4);
    // halt
    emit(encodeJ(opJ, 26'(progLen)));
    cycleLimit = 2 * progLen + 50;
    // ========================================================================
    // compare on falling edges
    // ========================================================================
    cur = 0;
    secStart = 0;
    @(negedge clk);
    checkVal("irAddr", irAddr, 32'd0);
    checkVal("cen", 32'(cen), 32'd1);
    checkVal("wen", 32'(wen), 32'd1);
    wait (rst === 1'b1);
    while (mPc != secEnd[5]) begin
      instr = imem[mPc[9:2]];
      refStep(mPc, instr, nextPc, wrAddr, wrVal, wrEn, isLoad, isStore, effAddr);
      checkVal("irAddr", irAddr, mPc);
      checkVal("rfWriteData", rfWriteData, wrEn ? wrVal : 32'd0);
      checkVal("cen", 32'(cen), 32'(!(isLoad || isStore)));
      checkVal("wen", 32'(wen), 32'(!isStore));
      if (isStore) begin
        checkVal("memAddr", 32'(memAddr), 32'(effAddr[memAddrWidth+1:2]));
        checkVal("memWriteData", memWriteData, mRegs[instr[20:16]]);
        mDmem[effAddr[memAddrWidth+1:2]] = mRegs[instr[20:16]];
      end
      // model writeback, r0 stays zero
      if (wrEn && wrAddr != 5'd0) begin
        mRegs[wrAddr] = wrVal;
      end
      mPc = nextPc;
      if (mPc >= secEnd[cur]) begin
        $display("test %0d %s: %0d errors", cur + 1, secName[cur], errors - secStart);
        if (errors != secStart) begin
          testFails++;
        end
        secStart = errors;
        cur++;
      end
      @(negedge clk);
    end
    $display("tests 6, failed %0d, checks %0d, errors %0d", testFails, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
